/* source/branch_pkg.sv */
package branch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;
    localparam int OPCODE_W   = 6;
    localparam int BR_OP_W    = 4;

    typedef logic [WORD_W-1:0]     word_t;      // data, address, instruction
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;    // inst[31:26]
    typedef logic [BR_OP_W-1:0]    br_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes of the 2RI16 / I26 group
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam opcode_t OPC_JIRL = 6'h13;
    localparam opcode_t OPC_B    = 6'h14;
    localparam opcode_t OPC_BL   = 6'h15;
    localparam opcode_t OPC_BEQ  = 6'h16;
    localparam opcode_t OPC_BNE  = 6'h17;
    localparam opcode_t OPC_BLT  = 6'h18;
    localparam opcode_t OPC_BGE  = 6'h19;
    localparam opcode_t OPC_BLTU = 6'h1A;
    localparam opcode_t OPC_BGEU = 6'h1B;

    // branch operations
    localparam br_op_t BR_NOP  = 4'd0;
    localparam br_op_t BR_BEQ  = 4'd1;
    localparam br_op_t BR_BNE  = 4'd2;
    localparam br_op_t BR_BLT  = 4'd3;
    localparam br_op_t BR_BGE  = 4'd4;
    localparam br_op_t BR_BLTU = 4'd5;
    localparam br_op_t BR_BGEU = 4'd6;
    localparam br_op_t BR_B    = 4'd7;
    localparam br_op_t BR_BL   = 4'd8;
    localparam br_op_t BR_JIRL = 4'd9;

    localparam reg_addr_t LINK_REG = 5'd1;  // ra that BL writes

endpackage

/* source/branch_decoder.sv */
`timescale 1ns/1ps

module branch_decoder (
    input  branch_pkg::word_t     pc_i,
    input  branch_pkg::word_t     inst_i,

    output branch_pkg::reg_addr_t rj_addr_o,
    output branch_pkg::reg_addr_t rd_addr_o,
    output logic                  rj_ren_o,
    output logic                  rd_ren_o,
    output branch_pkg::br_op_t    br_op_o,
    output logic                  wb_en_o,
    output branch_pkg::reg_addr_t wb_addr_o,
    output logic                  ine_o
);
    import branch_pkg::*;

    opcode_t   opcode;
    reg_addr_t rd;

    assign opcode    = inst_i[31:26];
    assign rd        = inst_i[4:0];
    assign rj_addr_o = inst_i[9:5];
    assign rd_addr_o = rd;

    always_comb begin
        case (opcode)
            OPC_BEQ: begin
                br_op_o   = BR_BEQ;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BNE: begin
                br_op_o   = BR_BNE;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BLT: begin
                br_op_o   = BR_BLT;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BGE: begin
                br_op_o   = BR_BGE;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BLTU: begin
                br_op_o   = BR_BLTU;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BGEU: begin
                br_op_o   = BR_BGEU;
                rj_ren_o  = 1'b1;
                rd_ren_o  = 1'b1;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_B: begin
                br_op_o   = BR_B;
                rj_ren_o  = 1'b0;        // offset only
                rd_ren_o  = 1'b0;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b0;
            end
            OPC_BL: begin
                br_op_o   = BR_BL;
                rj_ren_o  = 1'b0;
                rd_ren_o  = 1'b0;
                wb_en_o   = 1'b1;
                wb_addr_o = LINK_REG;    // implicit ra
                ine_o     = 1'b0;
            end
            OPC_JIRL: begin
                br_op_o   = BR_JIRL;
                rj_ren_o  = 1'b1;        // base register
                rd_ren_o  = 1'b0;
                wb_en_o   = 1'b1;
                wb_addr_o = rd;
                ine_o     = 1'b0;
            end
            default: begin
                // not a branch so flag it and do nothing else
                br_op_o   = BR_NOP;
                rj_ren_o  = 1'b0;
                rd_ren_o  = 1'b0;
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                ine_o     = 1'b1;
            end
        endcase
    end

endmodule

/* source/branch_regfile.sv */
`timescale 1ns/1ps

module branch_regfile (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  branch_pkg::reg_addr_t rj_addr_i,
    input  branch_pkg::reg_addr_t rd_addr_i,
    output branch_pkg::word_t     rj_data_o,
    output branch_pkg::word_t     rd_data_o,

    input  logic                  wb_en_i,
    input  branch_pkg::reg_addr_t wb_addr_i,
    input  branch_pkg::word_t     wb_data_i,

    input  logic                  init_we_i,
    input  branch_pkg::reg_addr_t init_addr_i,
    input  branch_pkg::word_t     init_data_i
);
    import branch_pkg::*;

    word_t regs [REG_NUM];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i) begin
            regs[wb_addr_i] <= wb_data_i;       // link write wins
        end else if (init_we_i) begin
            regs[init_addr_i] <= init_data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side with r0 hardwired to zero
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rj_data_o = (rj_addr_i == '0) ? '0 : regs[rj_addr_i];
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

/* source/branch_execute.sv */
`timescale 1ns/1ps

module branch_execute (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  issue_valid_i,
    input  branch_pkg::word_t     pc_i,
    input  branch_pkg::word_t     inst_i,
    input  branch_pkg::br_op_t    br_op_i,
    input  logic                  wb_en_i,
    input  branch_pkg::reg_addr_t wb_addr_i,
    input  logic                  ine_i,
    input  branch_pkg::reg_addr_t rj_addr_i,
    input  branch_pkg::reg_addr_t rd_addr_i,
    input  logic                  rj_ren_i,
    input  logic                  rd_ren_i,
    input  branch_pkg::word_t     rj_data_i,
    input  branch_pkg::word_t     rd_data_i,

    output logic                  ex_valid_o,
    output branch_pkg::word_t     ex_pc_o,
    output branch_pkg::word_t     ex_inst_o,
    output branch_pkg::br_op_t    ex_op_o,
    output branch_pkg::word_t     ex_rj_o,
    output logic                  ex_wb_en_o,
    output branch_pkg::reg_addr_t ex_wb_addr_o,
    output logic                  ex_ine_o,
    output logic                  ex_taken_o
);
    import branch_pkg::*;

    logic      valid_q;
    word_t     pc_q;
    word_t     inst_q;
    br_op_t    op_q;
    word_t     rj_q;
    word_t     rd_q;
    logic      wb_en_q;
    reg_addr_t wb_addr_q;
    logic      ine_q;

    logic      held_writes;
    logic      fwd_rj;
    logic      fwd_rd;
    word_t     link_val;
    logic      taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // forward the held link value since the regfile gets it one edge later
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign link_val    = pc_q + 32'd4;
    assign held_writes = valid_q && wb_en_q && (wb_addr_q != '0);
    assign fwd_rj      = held_writes && rj_ren_i && (rj_addr_i == wb_addr_q);
    assign fwd_rd      = held_writes && rd_ren_i && (rd_addr_i == wb_addr_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            pc_q      <= pc_i;
            inst_q    <= inst_i;
            op_q      <= br_op_i;
            wb_en_q   <= wb_en_i;
            wb_addr_q <= wb_addr_i;
            ine_q     <= ine_i;
            rj_q      <= fwd_rj ? link_val : rj_data_i;
            rd_q      <= fwd_rd ? link_val : rd_data_i;
        end
    end

    // condition on the held operands
    always_comb begin
        case (op_q)
            BR_BEQ:               taken = (rj_q == rd_q);
            BR_BNE:               taken = (rj_q != rd_q);
            BR_BLT:               taken = ($signed(rj_q) < $signed(rd_q));
            BR_BGE:               taken = ($signed(rj_q) >= $signed(rd_q));
            BR_BLTU:              taken = (rj_q < rd_q);
            BR_BGEU:              taken = (rj_q >= rd_q);
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    assign ex_valid_o   = valid_q;
    assign ex_pc_o      = pc_q;
    assign ex_inst_o    = inst_q;
    assign ex_op_o      = op_q;
    assign ex_rj_o      = rj_q;
    assign ex_wb_en_o   = wb_en_q;
    assign ex_wb_addr_o = wb_addr_q;
    assign ex_ine_o     = ine_q;
    assign ex_taken_o   = taken;

endmodule

/* source/branch_result.sv */
`timescale 1ns/1ps

module branch_result (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  ex_valid_i,
    input  branch_pkg::word_t     ex_pc_i,
    input  branch_pkg::word_t     ex_inst_i,
    input  branch_pkg::br_op_t    ex_op_i,
    input  branch_pkg::word_t     ex_rj_i,
    input  logic                  ex_wb_en_i,
    input  branch_pkg::reg_addr_t ex_wb_addr_i,
    input  logic                  ex_ine_i,
    input  logic                  ex_taken_i,

    output logic                  result_valid_o,
    output logic                  redirect_o,
    output branch_pkg::word_t     target_o,
    output logic                  ine_o,
    output logic                  wb_en_o,
    output branch_pkg::reg_addr_t wb_addr_o,
    output branch_pkg::word_t     wb_data_o,

    output logic                  rf_we_o,
    output branch_pkg::reg_addr_t rf_waddr_o,
    output branch_pkg::word_t     rf_wdata_o
);
    import branch_pkg::*;

    word_t off16_ext;
    word_t off26_ext;
    word_t target;
    word_t link_val;
    logic  wr_link;

    // offs16 = inst[25:10], offs26 = {inst[9:0], inst[25:10]}
    assign off16_ext = {{14{ex_inst_i[25]}}, ex_inst_i[25:10], 2'b00};
    assign off26_ext = {{4{ex_inst_i[9]}}, ex_inst_i[9:0], ex_inst_i[25:10], 2'b00};

    always_comb begin
        case (ex_op_i)
            BR_B, BR_BL: target = ex_pc_i + off26_ext;
            BR_JIRL:     target = ex_rj_i + off16_ext;     // register indirect
            default:     target = ex_pc_i + off16_ext;
        endcase
    end

    assign link_val = ex_pc_i + 32'd4;
    assign wr_link  = ex_valid_i && ex_wb_en_i && !ex_ine_i && (ex_wb_addr_i != '0);

    // regfile takes the link at the same edge the outputs register
    assign rf_we_o    = wr_link;
    assign rf_waddr_o = ex_wb_addr_i;
    assign rf_wdata_o = link_val;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
            ine_o          <= 1'b0;
            wb_en_o        <= 1'b0;
        end else begin
            result_valid_o <= ex_valid_i;
            redirect_o     <= ex_valid_i && ex_taken_i && !ex_ine_i;
            ine_o          <= ex_valid_i && ex_ine_i;
            wb_en_o        <= wr_link;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            target_o  <= target;
            wb_addr_o <= ex_wb_addr_i;
            wb_data_o <= link_val;
        end
    end

endmodule

/* source/branch_unit_top.sv */
`timescale 1ns/1ps

module branch_unit_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  issue_valid_i,
    input  branch_pkg::word_t     pc_i,
    input  branch_pkg::word_t     inst_i,

    input  logic                  init_we_i,
    input  branch_pkg::reg_addr_t init_addr_i,
    input  branch_pkg::word_t     init_data_i,

    output logic                  result_valid_o,
    output logic                  redirect_o,
    output branch_pkg::word_t     target_o,
    output logic                  ine_o,
    output logic                  wb_en_o,
    output branch_pkg::reg_addr_t wb_addr_o,
    output branch_pkg::word_t     wb_data_o
);
    import branch_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode / read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reg_addr_t rj_addr, rd_addr;
    logic      rj_ren, rd_ren;
    br_op_t    br_op;
    logic      dec_wb_en;
    reg_addr_t dec_wb_addr;
    logic      dec_ine;
    word_t     rj_data, rd_data;

    // execute stage
    logic      ex_valid;
    word_t     ex_pc, ex_inst, ex_rj;
    br_op_t    ex_op;
    logic      ex_wb_en;
    reg_addr_t ex_wb_addr;
    logic      ex_ine;
    logic      ex_taken;

    // link write-back
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    branch_decoder u_decoder (
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .rj_addr_o (rj_addr),
        .rd_addr_o (rd_addr),
        .rj_ren_o  (rj_ren),
        .rd_ren_o  (rd_ren),
        .br_op_o   (br_op),
        .wb_en_o   (dec_wb_en),
        .wb_addr_o (dec_wb_addr),
        .ine_o     (dec_ine)
    );

    branch_regfile u_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rj_addr_i   (rj_addr),
        .rd_addr_i   (rd_addr),
        .rj_data_o   (rj_data),
        .rd_data_o   (rd_data),
        .wb_en_i     (rf_we),
        .wb_addr_i   (rf_waddr),
        .wb_data_i   (rf_wdata),
        .init_we_i   (init_we_i),
        .init_addr_i (init_addr_i),
        .init_data_i (init_data_i)
    );

    branch_execute u_execute (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .br_op_i       (br_op),
        .wb_en_i       (dec_wb_en),
        .wb_addr_i     (dec_wb_addr),
        .ine_i         (dec_ine),
        .rj_addr_i     (rj_addr),
        .rd_addr_i     (rd_addr),
        .rj_ren_i      (rj_ren),
        .rd_ren_i      (rd_ren),
        .rj_data_i     (rj_data),
        .rd_data_i     (rd_data),
        .ex_valid_o    (ex_valid),
        .ex_pc_o       (ex_pc),
        .ex_inst_o     (ex_inst),
        .ex_op_o       (ex_op),
        .ex_rj_o       (ex_rj),
        .ex_wb_en_o    (ex_wb_en),
        .ex_wb_addr_o  (ex_wb_addr),
        .ex_ine_o      (ex_ine),
        .ex_taken_o    (ex_taken)
    );

    branch_result u_result (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_pc_i        (ex_pc),
        .ex_inst_i      (ex_inst),
        .ex_op_i        (ex_op),
        .ex_rj_i        (ex_rj),
        .ex_wb_en_i     (ex_wb_en),
        .ex_wb_addr_i   (ex_wb_addr),
        .ex_ine_i       (ex_ine),
        .ex_taken_i     (ex_taken),
        .result_valid_o (result_valid_o),
        .redirect_o     (redirect_o),
        .target_o       (target_o),
        .ine_o          (ine_o),
        .wb_en_o        (wb_en_o),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata)
    );

endmodule

/* testbench/branch_model.svh */
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// one expected result, in issue order
typedef struct {
    int unsigned cycle;         // cycle in which result_valid_o must be high
    logic        redirect;
    word_t       target;
    logic        ine;
    logic        wb_en;
    reg_addr_t   wb_addr;
    word_t       wb_data;
} exp_result_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic br_op_t model_decode(word_t inst);
    case (opcode_t'(inst[31:26]))
        OPC_BEQ:  return BR_BEQ;
        OPC_BNE:  return BR_BNE;
        OPC_BLT:  return BR_BLT;
        OPC_BGE:  return BR_BGE;
        OPC_BLTU: return BR_BLTU;
        OPC_BGEU: return BR_BGEU;
        OPC_B:    return BR_B;
        OPC_BL:   return BR_BL;
        OPC_JIRL: return BR_JIRL;
        default:  return BR_NOP;
    endcase
endfunction

function automatic logic model_taken(br_op_t op, word_t a, word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
        BR_BEQ:               return a == b;
        BR_BNE:               return a != b;
        BR_BLT:               return sa < sb;
        BR_BGE:               return !(sa < sb);
        BR_BLTU:              return a < b;
        BR_BGEU:              return !(a < b);
        BR_B, BR_BL, BR_JIRL: return 1'b1;
        default:              return 1'b0;    // an illegal op never redirects
    endcase
endfunction

function automatic word_t model_target(br_op_t op, word_t pc, word_t inst, word_t rj);
    logic signed [15:0] o16;
    logic signed [25:0] o26;
    logic signed [31:0] ext16;
    logic signed [31:0] ext26;
    o16   = inst[25:10];
    o26   = {inst[9:0], inst[25:10]};
    ext16 = o16;                            // sign extension by assignment
    ext26 = o26;
    if (op == BR_JIRL)
        return rj + (ext16 <<< 2);
    if (op == BR_B || op == BR_BL)
        return pc + (ext26 <<< 2);
    return pc + (ext16 <<< 2);
endfunction

// compare tasks
task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
        $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (exp !== act) begin
        $display("[FAIL] %0t ns %s expected r%0d actual r%0d", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
        $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
        stop_on_error();
    end
endtask

`endif

/* testbench/tb_branch_unit.sv */
`timescale 1ns/1ps

module tb_branch_unit;
    import branch_pkg::*;
    `include "branch_model.svh"

    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTS    = 2000;
    localparam int CLK_PERIOD   = 20;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      issue_valid;
    word_t     pc;
    word_t     inst;
    logic      init_we;
    reg_addr_t init_addr;
    word_t     init_data;
    logic      result_valid;
    logic      redirect;
    word_t     target;
    logic      ine;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    integer      seed = 32'he44e;
    word_t       mregs [REG_NUM];           // model register file
    exp_result_t exp_q [$];
    int unsigned cyc = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    branch_unit_top dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .issue_valid_i  (issue_valid),
        .pc_i           (pc),
        .inst_i         (inst),
        .init_we_i      (init_we),
        .init_addr_i    (init_addr),
        .init_data_i    (init_data),
        .result_valid_o (result_valid),
        .redirect_o     (redirect),
        .target_o       (target),
        .ine_o          (ine),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data)
    );

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue_one();
        opcode_t     opc_list [9] = '{OPC_JIRL, OPC_B, OPC_BL, OPC_BEQ, OPC_BNE,
                                      OPC_BLT, OPC_BGE, OPC_BLTU, OPC_BGEU};
        word_t       w;
        opcode_t     opc;
        br_op_t      op;
        reg_addr_t   rj;
        reg_addr_t   rd;
        exp_result_t e;
        w = $random(seed);
        if ({$random(seed)} % 10 < 9) begin
            opc = opc_list[{$random(seed)} % 9];
        end else begin
            opc = opcode_t'($random(seed));
            while (opc >= OPC_JIRL && opc <= OPC_BGEU)
                opc = opcode_t'($random(seed));
        end
        // low registers half the time so r1 dependences show up often
        if ({$random(seed)} % 2 == 0) w[9:5] = reg_addr_t'({$random(seed)} % 4);
        if ({$random(seed)} % 2 == 0) w[4:0] = reg_addr_t'({$random(seed)} % 4);
        w[31:26]    = opc;
        pc          = {$random(seed)} & 32'hffff_fffc;
        inst        = w;
        issue_valid = 1'b1;

        op         = model_decode(w);
        rj         = w[9:5];
        rd         = w[4:0];
        e.cycle    = cyc + 2;
        e.ine      = (op == BR_NOP);
        e.redirect = model_taken(op, mregs[rj], mregs[rd]);
        e.target   = model_target(op, pc, w, mregs[rj]);
        e.wb_en    = 1'b0;
        e.wb_addr  = '0;
        e.wb_data  = pc + 32'd4;
        if (op == BR_BL) begin
            e.wb_en   = 1'b1;
            e.wb_addr = LINK_REG;
        end else if (op == BR_JIRL && rd != 0) begin
            e.wb_en   = 1'b1;
            e.wb_addr = rd;
        end
        if (e.wb_en) mregs[e.wb_addr] = e.wb_data;   // in-order view
        exp_q.push_back(e);
    endtask

    initial begin
        int issued;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        pc          = '0;
        inst        = '0;
        init_we     = 1'b0;
        init_addr   = '0;
        init_data   = '0;
        for (int i = 0; i < REG_NUM; i++) mregs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        check_bit("result_valid_o", 1'b0, result_valid);
        check_bit("redirect_o", 1'b0, redirect);
        check_bit("wb_en_o", 1'b0, wb_en);
        check_bit("ine_o", 1'b0, ine);

        for (int r = 1; r < REG_NUM; r++) begin
            @(posedge clk);
            #2;
            init_we   = 1'b1;
            init_addr = reg_addr_t'(r);
            init_data = $random(seed);
            mregs[r]  = init_data;
        end
        @(posedge clk);
        #2 init_we = 1'b0;

        issued = 0;
        while (issued < NUM_INSTS) begin
            if ({$random(seed)} % 10 < 8) begin
                issue_one();
                issued++;
            end else begin
                issue_valid = 1'b0;
                inst        = $random(seed);    // junk on idle cycles
            end
            @(posedge clk);
            #2;
        end
        issue_valid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared", exp_q.size());
            stop_on_error();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard sampled mid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        exp_result_t e;
        if (rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result_valid_o high at %0t ns with no instruction outstanding", $time);
                stop_on_error();
            end
            e = exp_q.pop_front();
            if (e.cycle != cyc) begin
                $display("result at cycle %0d, expected at cycle %0d", cyc, e.cycle);
                stop_on_error();
            end
            check_bit("redirect_o", e.redirect, redirect);
            if (e.redirect) check_word("target_o", e.target, target);
            check_bit("ine_o", e.ine, ine);
            check_bit("wb_en_o", e.wb_en, wb_en);
            if (e.wb_en) begin
                check_addr("wb_addr_o", e.wb_addr, wb_addr);
                check_word("wb_data_o", e.wb_data, wb_data);
            end
        end else if (rst_n && exp_q.size() != 0 && exp_q[0].cycle <= cyc) begin
            $display("no result for the instruction due in cycle %0d", exp_q[0].cycle);
            stop_on_error();
        end
    end

    initial begin
        #((RESET_CYCLES + 31 + NUM_INSTS * 2 + 100) * CLK_PERIOD);
        $display("watchdog timeout, the test did not finish in time");
        stop_on_error();
    end

endmodule

/* src.f */
+incdir+testbench
source/branch_pkg.sv
source/branch_decoder.sv
source/branch_regfile.sv
source/branch_execute.sv
source/branch_result.sv
source/branch_unit_top.sv
testbench/tb_branch_unit.sv
